// ==== rtl/ahb_axi4_pkg.sv ====
package ahb_axi4_pkg;

  // --------------------------------------------------
  // Bus widths
  // --------------------------------------------------
  localparam int ADDR_W = 8;
  localparam int DATA_W = 8;
  localparam int LEN_W  = 8;

  // Sized for the longest burst (INCR16)
  localparam int FIFO_DEPTH = 16;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [LEN_W-1:0]  len_t;

  // Read FIFO word with the error bit on top of the data
  typedef logic [DATA_W:0]   rd_entry_t;

  // --------------------------------------------------
  // Encodings
  // --------------------------------------------------
  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    BUSY   = 2'b01,
    NONSEQ = 2'b10,
    SEQ    = 2'b11
  } htrans_t;

  typedef enum logic [2:0] {
    SINGLE = 3'b000,
    INCR   = 3'b001,
    WRAP4  = 3'b010,
    INCR4  = 3'b011,
    WRAP8  = 3'b100,
    INCR8  = 3'b101,
    WRAP16 = 3'b110,
    INCR16 = 3'b111
  } hburst_t;

  // Bit 1 flags an error response
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } xresp_t;

  typedef enum logic [1:0] {
    AHB_IDLE,
    AHB_WR_DATA,
    AHB_WR_RESP,
    AHB_RD_DATA
  } ahb_state_t;

  // AXI length field for an AHB burst code, anything unsupported is one beat
  function automatic len_t burst_len(hburst_t hburst);
    case (hburst)
      INCR4:   return len_t'(3);
      INCR8:   return len_t'(7);
      INCR16:  return len_t'(15);
      default: return len_t'(0);
    endcase
  endfunction

endpackage

// ==== rtl/burst_cmd_if.sv ====
interface burst_cmd_if;
  import ahb_axi4_pkg::*;

  // Command, one cycle pulse with its payload
  logic  cmd_valid;
  logic  cmd_write;
  addr_t cmd_addr;
  len_t  cmd_len;

  // Write completion, err valid with done
  logic  wr_done;
  logic  wr_err;

  modport ctrl (
    output cmd_valid, cmd_write, cmd_addr, cmd_len,
    input  wr_done, wr_err
  );

  modport wr (
    input  cmd_valid, cmd_write, cmd_addr, cmd_len,
    output wr_done, wr_err
  );

  modport rd (
    input  cmd_valid, cmd_write, cmd_addr, cmd_len
  );

endinterface

// ==== rtl/sync_fifo.sv ====
module sync_fifo #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 16
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             push_i,
  input  logic [WIDTH-1:0] push_data_i,
  input  logic             pop_i,
  output logic [WIDTH-1:0] head_o,
  output logic             full_o,
  output logic             empty_o
);

  typedef logic [$clog2(DEPTH)-1:0]   ptr_t;
  typedef logic [$clog2(DEPTH+1)-1:0] cnt_t;

  logic [WIDTH-1:0] mem [DEPTH];
  ptr_t             wr_ptr;
  ptr_t             rd_ptr;
  cnt_t             count;

  // Show-ahead, the oldest word is always on the output
  assign head_o  = mem[rd_ptr];
  assign full_o  = (count == cnt_t'(DEPTH));
  assign empty_o = (count == '0);

  always_ff @(posedge clk) begin
    if (push_i) begin
      mem[wr_ptr] <= push_data_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr <= (wr_ptr == ptr_t'(DEPTH - 1)) ? '0 : wr_ptr + ptr_t'(1);
      end
      if (pop_i) begin
        rd_ptr <= (rd_ptr == ptr_t'(DEPTH - 1)) ? '0 : rd_ptr + ptr_t'(1);
      end
      // Simultaneous push and pop leave the level unchanged
      case ({push_i, pop_i})
        2'b10:   count <= count + cnt_t'(1);
        2'b01:   count <= count - cnt_t'(1);
        default: count <= count;
      endcase
    end
  end

endmodule

// ==== rtl/ahb_side_ctrl.sv ====
module ahb_side_ctrl (
  input  logic                   clk,
  input  logic                   rst_n,
  input  ahb_axi4_pkg::htrans_t  htrans_i,
  input  ahb_axi4_pkg::hburst_t  hburst_i,
  input  logic                   hwrite_i,
  input  ahb_axi4_pkg::addr_t    haddr_i,
  input  ahb_axi4_pkg::data_t    hwdata_i,
  input  logic                   wr_full_i,
  input  logic                   rd_empty_i,
  input  ahb_axi4_pkg::rd_entry_t rd_head_i,
  output logic                   hready_o,
  output logic                   hresp_o,
  output ahb_axi4_pkg::data_t    hrdata_o,
  output logic                   wr_push_o,
  output ahb_axi4_pkg::data_t    wr_data_o,
  output logic                   rd_pop_o,
  burst_cmd_if.ctrl              cmd
);
  import ahb_axi4_pkg::*;

  ahb_state_t state;
  ahb_state_t state_nxt;
  len_t       beats_left;
  len_t       req_len;
  logic       dphase_busy;
  logic       wr_err_q;
  logic       addr_accept;
  logic       last_beat;

  // --------------------------------------------------
  // Address phase
  // --------------------------------------------------
  assign addr_accept = hready_o && (htrans_i == NONSEQ);
  assign req_len     = burst_len(hburst_i);

  // Remaining beats after the one in the data phase
  assign last_beat   = (beats_left == '0);

  // --------------------------------------------------
  // Data phase: HREADY and FIFO strobes
  // --------------------------------------------------
  always_comb begin
    hready_o  = 1'b1;
    wr_push_o = 1'b0;
    rd_pop_o  = 1'b0;
    case (state)
      AHB_WR_DATA: begin
        if (!dphase_busy) begin
          wr_push_o = !wr_full_i;
          // Last beat waits for the B response
          hready_o  = !wr_full_i && !last_beat;
        end
      end
      AHB_WR_RESP: begin
        hready_o = 1'b0;
      end
      AHB_RD_DATA: begin
        if (!dphase_busy) begin
          rd_pop_o = !rd_empty_i;
          hready_o = !rd_empty_i;
        end
      end
      default: begin
      end
    endcase
  end

  assign wr_data_o = hwdata_i;
  assign hrdata_o  = rd_head_i[DATA_W-1:0];
  assign hresp_o   = wr_err_q || (rd_pop_o && rd_head_i[DATA_W]);

  always_comb begin
    state_nxt = state;
    case (state)
      AHB_WR_DATA: if (wr_push_o && last_beat) state_nxt = AHB_WR_RESP;
      AHB_WR_RESP: if (cmd.wr_done) state_nxt = AHB_IDLE;
      AHB_RD_DATA: if (rd_pop_o && last_beat) state_nxt = AHB_IDLE;
      default:     state_nxt = state;
    endcase
    // A new burst may start as the previous one completes
    if (addr_accept) begin
      state_nxt = hwrite_i ? AHB_WR_DATA : AHB_RD_DATA;
    end
  end

  // --------------------------------------------------
  // State, beat counter, command pulse
  // --------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state         <= AHB_IDLE;
      beats_left    <= '0;
      dphase_busy   <= 1'b0;
      wr_err_q      <= 1'b0;
      cmd.cmd_valid <= 1'b0;
    end else begin
      state         <= state_nxt;
      cmd.cmd_valid <= addr_accept;
      // Error shows for the single cycle after wr_done
      wr_err_q      <= cmd.wr_done && cmd.wr_err;
      if (hready_o) begin
        dphase_busy <= (htrans_i == BUSY);
      end
      if (addr_accept) begin
        beats_left <= req_len;
      end else if ((wr_push_o || rd_pop_o) && !last_beat) begin
        beats_left <= beats_left - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (addr_accept) begin
      cmd.cmd_write <= hwrite_i;
      cmd.cmd_addr  <= haddr_i;
      cmd.cmd_len   <= req_len;
    end
  end

endmodule

// ==== rtl/axi_write_ch.sv ====
module axi_write_ch (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 wr_empty_i,
  input  ahb_axi4_pkg::data_t  wr_head_i,
  input  logic                 awready_i,
  input  logic                 wready_i,
  input  ahb_axi4_pkg::xresp_t bresp_i,
  input  logic                 bvalid_i,
  output logic                 wr_pop_o,
  output ahb_axi4_pkg::addr_t  awaddr_o,
  output ahb_axi4_pkg::len_t   awlen_o,
  output logic                 awvalid_o,
  output ahb_axi4_pkg::data_t  wdata_o,
  output logic                 wvalid_o,
  output logic                 wlast_o,
  output logic                 bready_o,
  burst_cmd_if.wr              cmd
);
  import ahb_axi4_pkg::*;

  logic start;
  logic w_open;
  len_t beat_cnt;
  logic w_hs;
  logic done_q;

  assign start = cmd.cmd_valid && cmd.cmd_write;

  // --------------------------------------------------
  // W channel straight from the FIFO head
  // --------------------------------------------------
  assign wvalid_o = w_open && !wr_empty_i;
  assign wdata_o  = wr_head_i;
  assign wlast_o  = (beat_cnt == awlen_o);
  assign w_hs     = wvalid_o && wready_i;
  assign wr_pop_o = w_hs;

  assign cmd.wr_done = done_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      awvalid_o <= 1'b0;
      w_open    <= 1'b0;
      beat_cnt  <= '0;
      bready_o  <= 1'b0;
      done_q    <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (start) begin
        awvalid_o <= 1'b1;
        w_open    <= 1'b1;
        beat_cnt  <= '0;
      end else if (awvalid_o && awready_i) begin
        awvalid_o <= 1'b0;
      end
      if (w_hs) begin
        beat_cnt <= beat_cnt + 1'b1;
        // Burst closes on the last beat, then wait for B
        if (wlast_o) begin
          w_open   <= 1'b0;
          bready_o <= 1'b1;
        end
      end
      if (bvalid_i && bready_o) begin
        bready_o <= 1'b0;
        done_q   <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      awaddr_o <= cmd.cmd_addr;
      awlen_o  <= cmd.cmd_len;
    end
    if (bvalid_i && bready_o) begin
      cmd.wr_err <= bresp_i[1];
    end
  end

endmodule

// ==== rtl/axi_read_ch.sv ====
module axi_read_ch (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    rd_full_i,
  input  logic                    arready_i,
  input  ahb_axi4_pkg::data_t     rdata_i,
  input  ahb_axi4_pkg::xresp_t    rresp_i,
  input  logic                    rlast_i,
  input  logic                    rvalid_i,
  output logic                    rd_push_o,
  output ahb_axi4_pkg::rd_entry_t rd_entry_o,
  output ahb_axi4_pkg::addr_t     araddr_o,
  output ahb_axi4_pkg::len_t      arlen_o,
  output logic                    arvalid_o,
  output logic                    rready_o,
  burst_cmd_if.rd                 cmd
);
  import ahb_axi4_pkg::*;

  logic start;
  logic r_open;

  assign start = cmd.cmd_valid && !cmd.cmd_write;

  // Accept R beats only while there is room for them
  assign rready_o   = r_open && !rd_full_i;
  assign rd_push_o  = rvalid_i && rready_o;
  assign rd_entry_o = {rresp_i[1], rdata_i};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      arvalid_o <= 1'b0;
      r_open    <= 1'b0;
    end else begin
      if (start) begin
        arvalid_o <= 1'b1;
        r_open    <= 1'b1;
      end else if (arvalid_o && arready_i) begin
        arvalid_o <= 1'b0;
      end
      if (rd_push_o && rlast_i) begin
        r_open <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      araddr_o <= cmd.cmd_addr;
      arlen_o  <= cmd.cmd_len;
    end
  end

endmodule

// ==== rtl/ahb_axi4_bridge.sv ====
module ahb_axi4_bridge (
  input  logic                  clk,
  input  logic                  rst_n,
  // AHB slave
  input  ahb_axi4_pkg::htrans_t htrans_i,
  input  ahb_axi4_pkg::hburst_t hburst_i,
  input  logic                  hwrite_i,
  input  ahb_axi4_pkg::addr_t   haddr_i,
  input  ahb_axi4_pkg::data_t   hwdata_i,
  output logic                  hready_o,
  output logic                  hresp_o,
  output ahb_axi4_pkg::data_t   hrdata_o,
  // AXI4 write
  output ahb_axi4_pkg::addr_t   awaddr_o,
  output ahb_axi4_pkg::len_t    awlen_o,
  output logic                  awvalid_o,
  input  logic                  awready_i,
  output ahb_axi4_pkg::data_t   wdata_o,
  output logic                  wvalid_o,
  output logic                  wlast_o,
  input  logic                  wready_i,
  input  ahb_axi4_pkg::xresp_t  bresp_i,
  input  logic                  bvalid_i,
  output logic                  bready_o,
  // AXI4 read
  output ahb_axi4_pkg::addr_t   araddr_o,
  output ahb_axi4_pkg::len_t    arlen_o,
  output logic                  arvalid_o,
  input  logic                  arready_i,
  input  ahb_axi4_pkg::data_t   rdata_i,
  input  ahb_axi4_pkg::xresp_t  rresp_i,
  input  logic                  rlast_i,
  input  logic                  rvalid_i,
  output logic                  rready_o
);
  import ahb_axi4_pkg::*;

  // --------------------------------------------------
  // FIFO side signals
  // --------------------------------------------------
  logic      wr_push;
  data_t     wr_data;
  logic      wr_pop;
  data_t     wr_head;
  logic      wr_full;
  logic      wr_empty;
  logic      rd_push;
  rd_entry_t rd_entry;
  logic      rd_pop;
  rd_entry_t rd_head;
  logic      rd_full;
  logic      rd_empty;

  burst_cmd_if u_cmd_if ();

  ahb_side_ctrl u_ahb_side_ctrl (
    .clk        (clk),
    .rst_n      (rst_n),
    .htrans_i   (htrans_i),
    .hburst_i   (hburst_i),
    .hwrite_i   (hwrite_i),
    .haddr_i    (haddr_i),
    .hwdata_i   (hwdata_i),
    .wr_full_i  (wr_full),
    .rd_empty_i (rd_empty),
    .rd_head_i  (rd_head),
    .hready_o   (hready_o),
    .hresp_o    (hresp_o),
    .hrdata_o   (hrdata_o),
    .wr_push_o  (wr_push),
    .wr_data_o  (wr_data),
    .rd_pop_o   (rd_pop),
    .cmd        (u_cmd_if.ctrl)
  );

  axi_write_ch u_axi_write_ch (
    .clk        (clk),
    .rst_n      (rst_n),
    .wr_empty_i (wr_empty),
    .wr_head_i  (wr_head),
    .awready_i  (awready_i),
    .wready_i   (wready_i),
    .bresp_i    (bresp_i),
    .bvalid_i   (bvalid_i),
    .wr_pop_o   (wr_pop),
    .awaddr_o   (awaddr_o),
    .awlen_o    (awlen_o),
    .awvalid_o  (awvalid_o),
    .wdata_o    (wdata_o),
    .wvalid_o   (wvalid_o),
    .wlast_o    (wlast_o),
    .bready_o   (bready_o),
    .cmd        (u_cmd_if.wr)
  );

  axi_read_ch u_axi_read_ch (
    .clk        (clk),
    .rst_n      (rst_n),
    .rd_full_i  (rd_full),
    .arready_i  (arready_i),
    .rdata_i    (rdata_i),
    .rresp_i    (rresp_i),
    .rlast_i    (rlast_i),
    .rvalid_i   (rvalid_i),
    .rd_push_o  (rd_push),
    .rd_entry_o (rd_entry),
    .araddr_o   (araddr_o),
    .arlen_o    (arlen_o),
    .arvalid_o  (arvalid_o),
    .rready_o   (rready_o),
    .cmd        (u_cmd_if.rd)
  );

  // Write data, AHB to AXI
  sync_fifo #(
    .WIDTH (DATA_W),
    .DEPTH (FIFO_DEPTH)
  ) u_wr_fifo (
    .clk         (clk),
    .rst_n       (rst_n),
    .push_i      (wr_push),
    .push_data_i (wr_data),
    .pop_i       (wr_pop),
    .head_o      (wr_head),
    .full_o      (wr_full),
    .empty_o     (wr_empty)
  );

  // Read data plus error bit, AXI to AHB
  sync_fifo #(
    .WIDTH ($bits(rd_entry_t)),
    .DEPTH (FIFO_DEPTH)
  ) u_rd_fifo (
    .clk         (clk),
    .rst_n       (rst_n),
    .push_i      (rd_push),
    .push_data_i (rd_entry),
    .pop_i       (rd_pop),
    .head_o      (rd_head),
    .full_o      (rd_full),
    .empty_o     (rd_empty)
  );

endmodule

// ==== bench/ahb_axi4_props.sv ====
module ahb_axi4_props (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                avalid_i,
  input  logic                aready_i,
  input  ahb_axi4_pkg::addr_t aaddr_i,
  input  ahb_axi4_pkg::len_t  alen_i,
  input  logic                wvalid_i,
  input  logic                wready_i,
  input  logic                wlast_i,
  input  logic                strobe_i,
  input  logic                block_i
);
  timeunit 1ns;
  timeprecision 1ps;
  import ahb_axi4_pkg::*;

  // Position of the next W beat inside the open burst
  len_t beat_cnt;

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beat_cnt <= '0;
    end else if (wvalid_i && wready_i) begin
      beat_cnt <= wlast_i ? '0 : beat_cnt + 1'b1;
    end
  end

  // --------------------------------------------------
  // Handshake rules
  // --------------------------------------------------
  a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
    avalid_i && !aready_i |=> avalid_i && $stable(aaddr_i) && $stable(alen_i))
    else $error("address request dropped or changed before ready");

  a_wlast_pos: assert property (@(posedge clk) disable iff (!rst_n)
    wvalid_i |-> (wlast_i == (beat_cnt == alen_i)))
    else $error("WLAST not on beat number awlen");

  a_fifo_guard: assert property (@(posedge clk) disable iff (!rst_n)
    !(strobe_i && block_i))
    else $error("FIFO strobe issued while the FIFO blocks it");

endmodule

// ==== bench/axi_slave_model.sv ====
module axi_slave_model #(
  parameter logic [7:0] FILL_XOR = 8'h5A,
  parameter logic [7:0] ERR_BASE = 8'hF0
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  ahb_axi4_pkg::addr_t  awaddr_i,
  input  ahb_axi4_pkg::len_t   awlen_i,
  input  logic                 awvalid_i,
  output logic                 awready_o,
  input  ahb_axi4_pkg::data_t  wdata_i,
  input  logic                 wvalid_i,
  input  logic                 wlast_i,
  output logic                 wready_o,
  output ahb_axi4_pkg::xresp_t bresp_o,
  output logic                 bvalid_o,
  input  logic                 bready_i,
  input  ahb_axi4_pkg::addr_t  araddr_i,
  input  ahb_axi4_pkg::len_t   arlen_i,
  input  logic                 arvalid_i,
  output logic                 arready_o,
  output ahb_axi4_pkg::data_t  rdata_o,
  output ahb_axi4_pkg::xresp_t rresp_o,
  output logic                 rlast_o,
  output logic                 rvalid_o,
  input  logic                 rready_i
);
  timeunit 1ns;
  timeprecision 1ps;
  import ahb_axi4_pkg::*;

  data_t mem [256];
  data_t wbuf [16];
  logic  aw_got;
  addr_t aw_addr;
  len_t  aw_len;
  logic  w_got;
  int    w_idx;
  logic  ar_got;
  addr_t ar_addr;
  len_t  ar_len;
  int    r_idx;

  initial begin
    for (int i = 0; i < 256; i++) begin
      mem[i] = data_t'(i) ^ FILL_XOR;
    end
  end

  // --------------------------------------------------
  // Write side, burst committed once AW and all W are in
  // --------------------------------------------------
  always @(posedge clk or negedge rst_n) begin : write_side
    logic  err;
    addr_t a;
    if (!rst_n) begin
      awready_o <= 1'b0;
      wready_o  <= 1'b0;
      bvalid_o  <= 1'b0;
      bresp_o   <= OKAY;
      aw_got    <= 1'b0;
      w_got     <= 1'b0;
      w_idx     <= 0;
    end else begin
      awready_o <= !aw_got && !(awvalid_i && awready_o) && ($urandom % 4 != 0);
      wready_o  <= !w_got && !(wvalid_i && wready_o && wlast_i) && ($urandom % 4 != 0);
      if (awvalid_i && awready_o) begin
        aw_got  <= 1'b1;
        aw_addr <= awaddr_i;
        aw_len  <= awlen_i;
      end
      if (wvalid_i && wready_o) begin
        wbuf[w_idx] <= wdata_i;
        w_idx       <= w_idx + 1;
        if (wlast_i) begin
          w_got <= 1'b1;
        end
      end
      if (aw_got && w_got && !bvalid_o && ($urandom % 2 == 0)) begin
        err = 1'b0;
        for (int i = 0; i <= int'(aw_len); i++) begin
          a = aw_addr + addr_t'(i);
          if (a >= ERR_BASE) begin
            err = 1'b1;
          end
        end
        // Any beat in the error range rejects the whole burst
        if (!err) begin
          for (int i = 0; i <= int'(aw_len); i++) begin
            mem[aw_addr + addr_t'(i)] <= wbuf[i];
          end
        end
        bresp_o  <= err ? SLVERR : OKAY;
        bvalid_o <= 1'b1;
      end
      if (bvalid_o && bready_i) begin
        bvalid_o <= 1'b0;
        aw_got   <= 1'b0;
        w_got    <= 1'b0;
        w_idx    <= 0;
      end
    end
  end

  // --------------------------------------------------
  // Read side with random gaps between beats
  // --------------------------------------------------
  always @(posedge clk or negedge rst_n) begin : read_side
    addr_t a;
    if (!rst_n) begin
      arready_o <= 1'b0;
      ar_got    <= 1'b0;
      rvalid_o  <= 1'b0;
      rdata_o   <= '0;
      rresp_o   <= OKAY;
      rlast_o   <= 1'b0;
      r_idx     <= 0;
    end else begin
      arready_o <= !ar_got && !(arvalid_i && arready_o) && ($urandom % 4 != 0);
      if (arvalid_i && arready_o) begin
        ar_got  <= 1'b1;
        ar_addr <= araddr_i;
        ar_len  <= arlen_i;
        r_idx   <= 0;
      end
      if (rvalid_o && rready_i) begin
        rvalid_o <= 1'b0;
        r_idx    <= r_idx + 1;
        if (rlast_o) begin
          ar_got <= 1'b0;
        end
      end else if (ar_got && !rvalid_o && ($urandom % 3 != 0)) begin
        a        = ar_addr + addr_t'(r_idx);
        rdata_o  <= mem[a];
        rresp_o  <= (a >= ERR_BASE) ? SLVERR : OKAY;
        rlast_o  <= (r_idx == int'(ar_len));
        rvalid_o <= 1'b1;
      end
    end
  end

endmodule

// ==== bench/tb_ahb_axi4.sv ====
module tb_ahb_axi4;
  timeunit 1ns;
  timeprecision 1ps;
  import ahb_axi4_pkg::*;

  localparam addr_t ERR_BASE = 8'hF0;
  localparam data_t FILL_XOR = 8'h5A;
  localparam int    TIMEOUT  = 2000;

  logic    clk;
  logic    rst_n;
  htrans_t htrans;
  hburst_t hburst;
  logic    hwrite;
  addr_t   haddr;
  data_t   hwdata;
  logic    hready;
  logic    hresp;
  data_t   hrdata;
  addr_t   awaddr;
  len_t    awlen;
  logic    awvalid;
  logic    awready;
  data_t   wdata;
  logic    wvalid;
  logic    wlast;
  logic    wready;
  xresp_t  bresp;
  logic    bvalid;
  logic    bready;
  addr_t   araddr;
  len_t    arlen;
  logic    arvalid;
  logic    arready;
  data_t   rdata;
  xresp_t  rresp;
  logic    rlast;
  logic    rvalid;
  logic    rready;

  data_t shadow [256];
  int    errors;

  // Completed AHB beats waiting for the compare process
  logic  obs_wr [$];
  logic  obs_last [$];
  addr_t obs_addr [$];
  data_t obs_data [$];
  logic  obs_resp [$];

  ahb_axi4_bridge UUT (
    .clk(clk), .rst_n(rst_n),
    .htrans_i(htrans), .hburst_i(hburst), .hwrite_i(hwrite), .haddr_i(haddr),
    .hwdata_i(hwdata), .hready_o(hready), .hresp_o(hresp), .hrdata_o(hrdata),
    .awaddr_o(awaddr), .awlen_o(awlen), .awvalid_o(awvalid), .awready_i(awready),
    .wdata_o(wdata), .wvalid_o(wvalid), .wlast_o(wlast), .wready_i(wready),
    .bresp_i(bresp), .bvalid_i(bvalid), .bready_o(bready),
    .araddr_o(araddr), .arlen_o(arlen), .arvalid_o(arvalid), .arready_i(arready),
    .rdata_i(rdata), .rresp_i(rresp), .rlast_i(rlast), .rvalid_i(rvalid), .rready_o(rready)
  );

  axi_slave_model #(.FILL_XOR(FILL_XOR), .ERR_BASE(ERR_BASE)) u_slave (
    .clk(clk), .rst_n(rst_n),
    .awaddr_i(awaddr), .awlen_i(awlen), .awvalid_i(awvalid), .awready_o(awready),
    .wdata_i(wdata), .wvalid_i(wvalid), .wlast_i(wlast), .wready_o(wready),
    .bresp_o(bresp), .bvalid_o(bvalid), .bready_i(bready),
    .araddr_i(araddr), .arlen_i(arlen), .arvalid_i(arvalid), .arready_o(arready),
    .rdata_o(rdata), .rresp_o(rresp), .rlast_o(rlast), .rvalid_o(rvalid), .rready_i(rready)
  );

  bind axi_write_ch ahb_axi4_props u_props (
    .clk(clk), .rst_n(rst_n), .avalid_i(awvalid_o), .aready_i(awready_i),
    .aaddr_i(awaddr_o), .alen_i(awlen_o), .wvalid_i(wvalid_o), .wready_i(wready_i),
    .wlast_i(wlast_o), .strobe_i(wr_pop_o), .block_i(wr_empty_i)
  );

  bind axi_read_ch ahb_axi4_props u_props (
    .clk(clk), .rst_n(rst_n), .avalid_i(arvalid_o), .aready_i(arready_i),
    .aaddr_i(araddr_o), .alen_i(arlen_o), .wvalid_i(1'b0), .wready_i(1'b0),
    .wlast_i(1'b0), .strobe_i(rd_push_o), .block_i(rd_full_i)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // --------------------------------------------------
  // Reference model and checks
  // --------------------------------------------------
  // Expected read byte in the low bits with the error flag on top
  function automatic logic [8:0] expect_beat(addr_t a);
    return {(a >= ERR_BASE), shadow[a]};
  endfunction

  function automatic int beats_of(hburst_t hb);
    case (hb)
      INCR4:   return 4;
      INCR8:   return 8;
      INCR16:  return 16;
      default: return 1;
    endcase
  endfunction

  task automatic compare_value(string name, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
      $display("mismatch %s: got 0x%h expected 0x%h at %0t", name, got, exp, $time);
      errors++;
    end
  endtask

  task automatic finish_run();
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  endtask

  initial begin : compare_proc
    addr_t      pend_addr [$];
    data_t      pend_data [$];
    logic       wr;
    logic       last;
    addr_t      a;
    data_t      d;
    logic       r;
    logic       burst_err;
    logic [8:0] exp;
    forever begin
      @(posedge clk);
      while (obs_wr.size() > 0) begin
        wr   = obs_wr.pop_front();
        last = obs_last.pop_front();
        a    = obs_addr.pop_front();
        d    = obs_data.pop_front();
        r    = obs_resp.pop_front();
        if (wr) begin
          pend_addr.push_back(a);
          pend_data.push_back(d);
          if (!last) begin
            compare_value("hresp", 32'(r), 32'(0));
          end else begin
            burst_err = 1'b0;
            foreach (pend_addr[i]) begin
              exp       = expect_beat(pend_addr[i]);
              burst_err = burst_err | exp[8];
            end
            compare_value("hresp", 32'(r), 32'(burst_err));
            if (!burst_err) begin
              foreach (pend_addr[i]) begin
                shadow[pend_addr[i]] = pend_data[i];
              end
            end
            pend_addr.delete();
            pend_data.delete();
          end
        end else begin
          exp = expect_beat(a);
          compare_value("hrdata", 32'(d), 32'(exp[7:0]));
          compare_value("hresp", 32'(r), 32'(exp[8]));
        end
      end
    end
  end

  // --------------------------------------------------
  // AHB master
  // --------------------------------------------------
  task automatic log_beat(logic wr, logic last, addr_t a, data_t d, logic r);
    obs_wr.push_back(wr);
    obs_last.push_back(last);
    obs_addr.push_back(a);
    obs_data.push_back(d);
    obs_resp.push_back(r);
  endtask

  // One burst with a BUSY cycle after beat busy_after unless that is the last beat
  task automatic drive_burst(logic wr, addr_t start, hburst_t hb, int busy_after);
    htrans_t ent_trans [40];
    addr_t   ent_addr [40];
    int      ent_beat [40];
    data_t   wdat [16];
    int      n;
    int      m;
    int      k;
    int      dp;
    int      wait_cnt;
    logic    done;
    n = beats_of(hb);
    m = 0;
    for (int b = 0; b < n; b++) begin
      wdat[b]      = data_t'($urandom);
      ent_trans[m] = (b == 0) ? NONSEQ : SEQ;
      ent_addr[m]  = start + addr_t'(b);
      ent_beat[m]  = b;
      m++;
      if (b == busy_after && b < n - 1) begin
        ent_trans[m] = BUSY;
        ent_addr[m]  = start + addr_t'(b + 1);
        ent_beat[m]  = -1;
        m++;
      end
    end
    ent_trans[m] = IDLE;
    ent_addr[m]  = '0;
    ent_beat[m]  = -1;
    m++;
    k        = 0;
    dp       = -1;
    done     = 1'b0;
    wait_cnt = 0;
    @(posedge clk);
    htrans <= ent_trans[0];
    haddr  <= ent_addr[0];
    hburst <= hb;
    hwrite <= wr;
    while (!done) begin
      @(negedge clk);
      if (hready) begin
        wait_cnt = 0;
        if (dp >= 0 && ent_beat[dp] >= 0) begin
          log_beat(wr, ent_beat[dp] == n - 1, ent_addr[dp],
                   wr ? wdat[ent_beat[dp]] : hrdata, hresp);
        end
        if (dp == m - 2) begin
          done = 1'b1;
        end else begin
          @(posedge clk);
          dp = k;
          k++;
          htrans <= ent_trans[k];
          haddr  <= ent_addr[k];
          if (wr && ent_beat[dp] >= 0) begin
            hwdata <= wdat[ent_beat[dp]];
          end
        end
      end else begin
        wait_cnt++;
        if (wait_cnt > TIMEOUT) begin
          $display("timeout: HREADY held low for %0d cycles at 0x%h", TIMEOUT, start);
          errors++;
          finish_run();
        end
      end
    end
  endtask

  initial begin : main
    hburst_t hb;
    int      wait_cnt;
    void'($urandom(5));
    errors = 0;
    rst_n  = 1'b0;
    htrans = IDLE;
    hburst = SINGLE;
    hwrite = 1'b0;
    haddr  = '0;
    hwdata = '0;
    for (int i = 0; i < 256; i++) begin
      shadow[i] = data_t'(i) ^ FILL_XOR;
    end
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    compare_value("hready", 32'(hready), 32'(1));
    compare_value("hresp", 32'(hresp), 32'(0));
    compare_value("awvalid", 32'(awvalid), 32'(0));
    compare_value("wvalid", 32'(wvalid), 32'(0));
    compare_value("bready", 32'(bready), 32'(0));
    compare_value("arvalid", 32'(arvalid), 32'(0));
    compare_value("rready", 32'(rready), 32'(0));

    // Single transfers
    drive_burst(1'b1, 8'h10, SINGLE, -1);
    drive_burst(1'b0, 8'h10, SINGLE, -1);

    // Fixed length bursts read back in order
    drive_burst(1'b1, 8'h20, INCR4, -1);
    drive_burst(1'b0, 8'h20, INCR4, -1);
    drive_burst(1'b1, 8'h40, INCR8, -1);
    drive_burst(1'b0, 8'h40, INCR8, -1);
    drive_burst(1'b1, 8'h60, INCR16, -1);
    drive_burst(1'b0, 8'h60, INCR16, -1);

    // Random bursts under slave stalls
    for (int i = 0; i < 8; i++) begin
      case ($urandom % 4)
        0:       hb = SINGLE;
        1:       hb = INCR4;
        2:       hb = INCR8;
        default: hb = INCR16;
      endcase
      drive_burst(1'b1, addr_t'($urandom % 200), hb, -1);
      drive_burst(1'b0, addr_t'($urandom % 200), hb, -1);
    end

    // Error range
    drive_burst(1'b1, 8'hF4, INCR4, -1);
    drive_burst(1'b0, 8'hF4, INCR4, -1);
    drive_burst(1'b1, 8'hF0, SINGLE, -1);
    drive_burst(1'b0, 8'hF8, SINGLE, -1);

    // BUSY inside bursts
    drive_burst(1'b1, 8'h80, INCR8, 2);
    drive_burst(1'b0, 8'h80, INCR8, 5);
    drive_burst(1'b1, 8'hA0, INCR16, 0);
    drive_burst(1'b0, 8'hA0, INCR16, 9);

    wait_cnt = 0;
    while (obs_wr.size() > 0) begin
      @(posedge clk);
      wait_cnt++;
      if (wait_cnt > TIMEOUT) begin
        $display("timeout: compare queue did not drain");
        errors++;
        break;
      end
    end
    finish_run();
  end

endmodule

// ==== build.f ====
rtl/ahb_axi4_pkg.sv
rtl/burst_cmd_if.sv
rtl/sync_fifo.sv
rtl/ahb_side_ctrl.sv
rtl/axi_write_ch.sv
rtl/axi_read_ch.sv
rtl/ahb_axi4_bridge.sv
bench/ahb_axi4_props.sv
bench/axi_slave_model.sv
bench/tb_ahb_axi4.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the bridge testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_ahb_axi4 -f build.f -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

grep -q '^\*\* PASS \*\*$' sim.log
